// File: verilog/stb_pkg.sv
// shared state types and default sizes for the strobe subsystem
// CNT_WIDTH_DEF must stay even since counter and adders work in halves

package stb_pkg;

	// period_meter FSM, one-hot with two spare bits
	typedef enum logic [6:0] {
		SKIP_EDGE  = 7'b000_0001,
		WAIT_START = 7'b000_0010,
		WAIT_END   = 7'b000_0100,
		CHECK      = 7'b000_1000,
		DONE       = 7'b001_0000
	} meter_state_e;

	// host handshake FSM
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		ARM   = 2'd1,
		PASS  = 2'd2,
		DRAIN = 2'd3
	} req_state_e;

	localparam int CNT_WIDTH_DEF  = 32; // timestamp bits
	localparam int ZERO_HOLD_DEF  = 1;  // strobe low cycles per period
	localparam int MIN_PERIOD_DEF = 16; // shorter periods raise err_o

endpackage

// File: verilog/sync_ff.sv
// shift-chain synchronizer for an asynchronous input
// STAGES of 2 or more; every stage clears to 0 on reset

module sync_ff #(
	parameter int WIDTH  = 1,
	parameter int STAGES = 2
) (
	input  logic             clk_i,
	input  logic             arst_i,
	input  logic [WIDTH-1:0] data_i,
	output logic [WIDTH-1:0] data_o
);

	logic [WIDTH-1:0] chain [STAGES];

	always_ff @(posedge clk_i or negedge arst_i) begin
		if (!arst_i) begin
			for (int i = 0; i < STAGES; i++)
				chain[i] <= '0;
		end else begin
			chain[0] <= data_i; // may go metastable
			for (int i = 1; i < STAGES; i++)
				chain[i] <= chain[i-1];
		end
	end

	assign data_o = chain[STAGES-1];

endmodule

// File: verilog/split_counter.sv
// free-running timestamp counter split into two halves
// t_cnt_o lags the internal count by 2 cycles, which is a constant offset
// T_CNT_WIDTH must be even; wrap-around is not handled by the users

module split_counter #(
	parameter int T_CNT_WIDTH = stb_pkg::CNT_WIDTH_DEF
) (
	input  logic                   clk_i,
	input  logic                   arst_i,
	output logic [T_CNT_WIDTH-1:0] t_cnt_o
);

	localparam int HALF = T_CNT_WIDTH / 2;

	logic [HALF-1:0] low_q;
	logic [HALF-1:0] low_d1_q;  // low half delayed to meet the carry
	logic [HALF-1:0] high_q;
	logic [HALF-1:0] low_inc;
	logic            low_carry;
	logic            carry_q;

	assign {low_carry, low_inc} = {1'b0, low_q} + 1'b1;

	// low half runs every cycle
	always_ff @(posedge clk_i or negedge arst_i) begin
		if (!arst_i) begin
			low_q    <= '0;
			low_d1_q <= '0;
			carry_q  <= 1'b0;
		end else begin
			low_q    <= low_inc;
			low_d1_q <= low_q;
			carry_q  <= low_carry; // short path into the high half
		end
	end

	// high half takes the carry one cycle late
	always_ff @(posedge clk_i or negedge arst_i) begin
		if (!arst_i)
			high_q <= '0;
		else
			high_q <= high_q + HALF'(carry_q);
	end

	always_ff @(posedge clk_i or negedge arst_i) begin
		if (!arst_i)
			t_cnt_o <= '0;
		else
			t_cnt_o <= {high_q, low_d1_q};
	end

endmodule

// File: verilog/two_cycle_adder.sv
// two-stage pipelined adder that takes a new operand pair every cycle
// result and valid_o appear 2 cycles after valid_i
// WIDTH must be even; the sum wraps modulo 2**WIDTH

module two_cycle_adder #(
	parameter int WIDTH = stb_pkg::CNT_WIDTH_DEF
) (
	input  logic             clk_i,
	input  logic             arst_i,
	input  logic [WIDTH-1:0] a_i,
	input  logic [WIDTH-1:0] b_i,
	input  logic             valid_i,
	output logic [WIDTH-1:0] res_o,
	output logic             valid_o
);

	localparam int HALF = WIDTH / 2;

	logic [HALF:0]   lo_sum;
	logic [HALF-1:0] lo_q;
	logic [HALF-1:0] a_hi_q;
	logic [HALF-1:0] b_hi_q;
	logic            carry_q;
	logic            valid_q;

	assign lo_sum = {1'b0, a_i[HALF-1:0]} + {1'b0, b_i[HALF-1:0]};

	// stage 1 adds the low halves
	always_ff @(posedge clk_i) begin
		lo_q    <= lo_sum[HALF-1:0];
		carry_q <= lo_sum[HALF];
		a_hi_q  <= a_i[WIDTH-1:HALF];
		b_hi_q  <= b_i[WIDTH-1:HALF];
	end

	// stage 2 adds the high halves plus carry
	always_ff @(posedge clk_i)
		res_o <= {a_hi_q + b_hi_q + HALF'(carry_q), lo_q};

	always_ff @(posedge clk_i or negedge arst_i) begin
		if (!arst_i) begin
			valid_q <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			valid_q <= valid_i;
			valid_o <= valid_q;
		end
	end

endmodule

// File: verilog/period_meter.sv
// measures the sig_i period between the 2nd and 3rd synced rising edges
// first edge after reset or after an error is skipped as it may be partial
// measures once; counter wrap between the two stamps is not handled

module period_meter #(
	parameter int T_CNT_WIDTH = stb_pkg::CNT_WIDTH_DEF,
	parameter int MIN_PERIOD  = stb_pkg::MIN_PERIOD_DEF
) (
	input  logic                   clk_i,
	input  logic                   arst_i,
	input  logic                   sig_i,
	input  logic [T_CNT_WIDTH-1:0] t_cnt_i,
	output logic [T_CNT_WIDTH-1:0] period_o,
	output logic                   period_valid_o,
	output logic                   err_o
);

	localparam logic [T_CNT_WIDTH-1:0] MIN_CNT = T_CNT_WIDTH'(MIN_PERIOD);

	stb_pkg::meter_state_e state_q;
	stb_pkg::meter_state_e state_d;

	logic                   sig_sync;
	logic                   sig_prev;
	logic                   sig_rise;
	logic [T_CNT_WIDTH-1:0] t_start_q;
	logic [T_CNT_WIDTH-1:0] t_end_q;
	logic [T_CNT_WIDTH-1:0] diff;
	logic                   too_short;

	//----------------------------------------------------------------------
	// input sync and edge detect
	//----------------------------------------------------------------------
	sync_ff #(
		.WIDTH (1),
		.STAGES(2)
	) u_sig_sync (
		.clk_i (clk_i),
		.arst_i(arst_i),
		.data_i(sig_i),
		.data_o(sig_sync)
	);

	always_ff @(posedge clk_i or negedge arst_i) begin
		if (!arst_i)
			sig_prev <= 1'b0;
		else
			sig_prev <= sig_sync;
	end

	assign sig_rise = sig_sync & ~sig_prev;

	//----------------------------------------------------------------------
	// measurement FSM
	//----------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		unique case (state_q)
			stb_pkg::SKIP_EDGE: begin
				if (sig_rise)
					state_d = stb_pkg::WAIT_START;
			end
			stb_pkg::WAIT_START: begin
				if (sig_rise)
					state_d = stb_pkg::WAIT_END;
			end
			stb_pkg::WAIT_END: begin
				if (sig_rise)
					state_d = stb_pkg::CHECK;
			end
			stb_pkg::CHECK:  state_d = too_short ? stb_pkg::SKIP_EDGE : stb_pkg::DONE;
			stb_pkg::DONE:   state_d = stb_pkg::DONE; // hold until reset
			default:         state_d = stb_pkg::SKIP_EDGE;
		endcase
	end

	// both stamps see the same t_cnt latency
	always_ff @(posedge clk_i) begin
		if (state_q == stb_pkg::WAIT_START && sig_rise)
			t_start_q <= t_cnt_i;
		if (state_q == stb_pkg::WAIT_END && sig_rise)
			t_end_q <= t_cnt_i;
	end

	assign diff      = t_end_q - t_start_q;
	assign too_short = diff < MIN_CNT;

	always_ff @(posedge clk_i or negedge arst_i) begin
		if (!arst_i) begin
			state_q        <= stb_pkg::SKIP_EDGE;
			period_o       <= '0;
			period_valid_o <= 1'b0;
			err_o          <= 1'b0;
		end else begin
			state_q        <= state_d;
			period_valid_o <= 1'b0;
			if (state_q == stb_pkg::CHECK) begin
				err_o <= too_short;
				if (!too_short) begin
					period_o       <= diff;
					period_valid_o <= 1'b1; // 2 cycles after the 3rd edge
				end
			end
		end
	end

endmodule

// File: verilog/stb_gen.sv
// strobe scheduler locked to a measured period P
// strobe is low for ZERO_HOLD_CYCLES at the end of each period, high otherwise
// needs P >= ZERO_HOLD_CYCLES + 5 and no counter wrap while running
// T_CNT_WIDTH must be even

module stb_gen #(
	parameter int T_CNT_WIDTH      = stb_pkg::CNT_WIDTH_DEF,
	parameter int ZERO_HOLD_CYCLES = stb_pkg::ZERO_HOLD_DEF
) (
	input  logic                   clk_i,
	input  logic                   arst_i,
	input  logic [T_CNT_WIDTH-1:0] t_cnt_i,
	input  logic [T_CNT_WIDTH-1:0] period_i,
	input  logic                   period_valid_i,
	output logic                   int_stb_o,
	output logic                   rdy_o
);

	localparam int HALF     = T_CNT_WIDTH / 2;
	localparam int CMP_LAT  = 2; // t_cnt match to hit, also the re-arm slip
	localparam int HOLD_IDX = 0;
	localparam int END_IDX  = 1;

	localparam logic [T_CNT_WIDTH-1:0] END_OFFSET  = T_CNT_WIDTH'(CMP_LAT);
	localparam logic [T_CNT_WIDTH-1:0] HOLD_OFFSET =
		T_CNT_WIDTH'(ZERO_HOLD_CYCLES + CMP_LAT);

	logic [T_CNT_WIDTH-1:0] span_q [2]; // cycles from arm to deadline
	logic                   start_q;
	logic                   arm;
	logic                   hold_hit;
	logic                   end_hit;

	// offsets into the period, taken once per measurement
	always_ff @(posedge clk_i) begin
		if (period_valid_i) begin
			span_q[HOLD_IDX] <= period_i - HOLD_OFFSET;
			span_q[END_IDX]  <= period_i - END_OFFSET;
		end
	end

	assign arm = start_q | end_hit; // first arm, then every period end

	//----------------------------------------------------------------------
	// deadline pipes: adder, latch, split compare
	//----------------------------------------------------------------------
	for (genvar i = 0; i < 2; i++) begin : g_deadline
		logic [T_CNT_WIDTH-1:0] sum;
		logic                   sum_valid;
		logic [T_CNT_WIDTH-1:0] dl_q;
		logic                   dl_valid_q;
		logic                   eq_lo_q;
		logic                   eq_hi_q;
		logic                   hit_q;

		two_cycle_adder #(
			.WIDTH(T_CNT_WIDTH)
		) u_add (
			.clk_i  (clk_i),
			.arst_i (arst_i),
			.a_i    (t_cnt_i),
			.b_i    (span_q[i]),
			.valid_i(arm),
			.res_o  (sum),
			.valid_o(sum_valid)
		);

		always_ff @(posedge clk_i) begin
			if (sum_valid)
				dl_q <= sum;
		end

		always_ff @(posedge clk_i or negedge arst_i) begin
			if (!arst_i) begin
				dl_valid_q <= 1'b0;
				eq_lo_q    <= 1'b0;
				eq_hi_q    <= 1'b0;
				hit_q      <= 1'b0;
			end else begin
				if (sum_valid)
					dl_valid_q <= 1'b1;
				eq_lo_q <= dl_valid_q && (t_cnt_i[HALF-1:0] == dl_q[HALF-1:0]);
				eq_hi_q <= dl_valid_q &&
					(t_cnt_i[T_CNT_WIDTH-1:HALF] == dl_q[T_CNT_WIDTH-1:HALF]);
				hit_q   <= eq_lo_q & eq_hi_q;
			end
		end
	end

	assign hold_hit = g_deadline[HOLD_IDX].hit_q;
	assign end_hit  = g_deadline[END_IDX].hit_q;

	//----------------------------------------------------------------------
	// strobe and ready
	//----------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge arst_i) begin
		if (!arst_i) begin
			start_q   <= 1'b0;
			int_stb_o <= 1'b0;
			rdy_o     <= 1'b0;
		end else begin
			start_q <= period_valid_i;
			if (end_hit) begin
				int_stb_o <= 1'b1;
				rdy_o     <= 1'b1; // sticky from the first period end
			end else if (hold_hit) begin
				int_stb_o <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/stb_req_port.sv
// four-phase req/ack gate in front of the strobe
// ack_o and the stb_o gate move only in cycles where int_stb rises,
// so stb_o carries whole strobe periods only
// req_i is sampled at the clock and must stay high until ack_o rises

module stb_req_port (
	input  logic clk_i,
	input  logic arst_i,
	input  logic rdy_i,
	input  logic int_stb_i,
	input  logic req_i,
	output logic ack_o,
	output logic stb_o
);

	stb_pkg::req_state_e state_q;
	stb_pkg::req_state_e state_d;

	logic stb_prev;
	logic stb_rise;

	always_ff @(posedge clk_i or negedge arst_i) begin
		if (!arst_i)
			stb_prev <= 1'b0;
		else
			stb_prev <= int_stb_i;
	end

	assign stb_rise = int_stb_i & ~stb_prev;

	always_comb begin
		state_d = state_q;
		case (state_q)
			stb_pkg::IDLE:  if (req_i && rdy_i) state_d = stb_pkg::ARM;
			stb_pkg::ARM:   if (stb_rise)       state_d = stb_pkg::PASS;
			stb_pkg::PASS:  if (!req_i)         state_d = stb_pkg::DRAIN;
			stb_pkg::DRAIN: if (stb_rise)       state_d = stb_pkg::IDLE;
			default:                            state_d = stb_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_i) begin
		if (!arst_i)
			state_q <= stb_pkg::IDLE;
		else
			state_q <= state_d;
	end

	// ack switches in the rising cycle itself, not one later
	assign ack_o = (state_q == stb_pkg::ARM && stb_rise) ||
		(state_q == stb_pkg::PASS) ||
		(state_q == stb_pkg::DRAIN && !stb_rise);

	assign stb_o = ack_o & int_stb_i;

endmodule

// File: verilog/stb_sys_top.sv
// strobe subsystem: period meter, strobe generator and host req/ack gate
// measures once after reset or after an error and does not track drift
// T_CNT_WIDTH must be even

module stb_sys_top #(
	parameter int T_CNT_WIDTH      = stb_pkg::CNT_WIDTH_DEF,
	parameter int ZERO_HOLD_CYCLES = stb_pkg::ZERO_HOLD_DEF,
	parameter int MIN_PERIOD       = stb_pkg::MIN_PERIOD_DEF
) (
	input  logic                   clk_i,
	input  logic                   arst_i,
	input  logic                   sig_i,
	input  logic                   req_i,
	output logic [T_CNT_WIDTH-1:0] period_o,
	output logic                   err_o,
	output logic                   rdy_o,
	output logic                   stb_o,
	output logic                   ack_o,
	output logic                   debug_stb_o
);

	logic [T_CNT_WIDTH-1:0] t_cnt;
	logic                   period_valid;
	logic                   int_stb;

	split_counter #(
		.T_CNT_WIDTH(T_CNT_WIDTH)
	) u_counter (
		.clk_i  (clk_i),
		.arst_i (arst_i),
		.t_cnt_o(t_cnt)
	);

	period_meter #(
		.T_CNT_WIDTH(T_CNT_WIDTH),
		.MIN_PERIOD (MIN_PERIOD)
	) u_meter (
		.clk_i         (clk_i),
		.arst_i        (arst_i),
		.sig_i         (sig_i),
		.t_cnt_i       (t_cnt),
		.period_o      (period_o),
		.period_valid_o(period_valid),
		.err_o         (err_o)
	);

	stb_gen #(
		.T_CNT_WIDTH     (T_CNT_WIDTH),
		.ZERO_HOLD_CYCLES(ZERO_HOLD_CYCLES)
	) u_gen (
		.clk_i         (clk_i),
		.arst_i        (arst_i),
		.t_cnt_i       (t_cnt),
		.period_i      (period_o),
		.period_valid_i(period_valid),
		.int_stb_o     (int_stb),
		.rdy_o         (rdy_o)
	);

	stb_req_port u_req (
		.clk_i    (clk_i),
		.arst_i   (arst_i),
		.rdy_i    (rdy_o),
		.int_stb_i(int_stb),
		.req_i    (req_i),
		.ack_o    (ack_o),
		.stb_o    (stb_o)
	);

	assign debug_stb_o = int_stb; // free-running, not gated

endmodule

// File: verification/stb_sys_tb.sv
// testbench for stb_sys_top with the package default widths and limits
// the DUT measures only once, so every test starts with its own reset
// sig_i periods are whole clock cycles, drawn from 40 to 200
// checks are concurrent and immediate assertions, so build with assertions on

module stb_sys_tb;

	localparam int T_CNT_WIDTH  = stb_pkg::CNT_WIDTH_DEF;
	localparam int ZERO_HOLD    = stb_pkg::ZERO_HOLD_DEF;
	localparam int MIN_PERIOD   = stb_pkg::MIN_PERIOD_DEF;
	localparam int N_PERIODS    = 4;   // three plain tests plus the error test
	localparam int SHORT_PERIOD = 8;   // below MIN_PERIOD
	localparam int SEL_RDY      = 0;
	localparam int SEL_ERR      = 1;
	localparam int SEL_ACK      = 2;

	logic                   clk_i  = 1'b0;
	logic                   arst_i = 1'b1;
	logic                   sig_i  = 1'b0;
	logic                   req_i  = 1'b0;
	logic [T_CNT_WIDTH-1:0] period_o;
	logic                   err_o;
	logic                   rdy_o;
	logic                   stb_o;
	logic                   ack_o;
	logic                   debug_stb_o;

	int unsigned            sig_period = 0;   // 0 holds sig_i low
	int unsigned            cur_per    = 0;
	int unsigned            ph         = 0;
	logic [T_CNT_WIDTH-1:0] exp_period = '0;
	logic                   in_reset_win = 1'b0;
	integer                 seed = 32'h37d2_e454;
	int unsigned            periods [N_PERIODS];
	int                     fail_count   = 0;
	int                     fails_before = 0;
	int                     tests_run    = 0;
	string                  cur_test     = "none";

	logic                   stb_q;
	logic                   stb_rise;
	logic                   seen_rise;
	logic [T_CNT_WIDTH-1:0] gap_cnt;
	logic [T_CNT_WIDTH-1:0] low_cnt;

	stb_sys_top #(
		.T_CNT_WIDTH     (T_CNT_WIDTH),
		.ZERO_HOLD_CYCLES(ZERO_HOLD),
		.MIN_PERIOD      (MIN_PERIOD)
	) uut (
		.clk_i      (clk_i),
		.arst_i     (arst_i),
		.sig_i      (sig_i),
		.req_i      (req_i),
		.period_o   (period_o),
		.err_o      (err_o),
		.rdy_o      (rdy_o),
		.stb_o      (stb_o),
		.ack_o      (ack_o),
		.debug_stb_o(debug_stb_o)
	);

	initial begin
		forever #10 clk_i = ~clk_i;
	end

	// square wave on sig_i, a new period takes effect at the next rising edge
	always @(posedge clk_i) begin
		if (sig_period == 0) begin
			sig_i   <= 1'b0;
			cur_per <= 0;
			ph      <= 0;
		end else if (cur_per == 0 || ph == cur_per - 1) begin
			sig_i   <= 1'b1;
			cur_per <= sig_period;
			ph      <= 0;
		end else begin
			sig_i <= (ph + 1 < cur_per / 2);
			ph    <= ph + 1;
		end
	end

	//--------------------------------------------------------------------
	// strobe tracking and assertions
	//--------------------------------------------------------------------
	assign stb_rise = debug_stb_o & ~stb_q;

	always @(posedge clk_i or negedge arst_i) begin
		if (!arst_i) begin
			stb_q     <= 1'b0;
			seen_rise <= 1'b0;
			gap_cnt   <= '0;
			low_cnt   <= '0;
		end else begin
			stb_q <= debug_stb_o;
			if (stb_rise) begin
				seen_rise <= 1'b1;
				gap_cnt   <= 1;
			end else begin
				gap_cnt <= gap_cnt + 1;
			end
			low_cnt <= debug_stb_o ? '0 : low_cnt + 1; // cycles low before a rise
		end
	end

	a_reset_quiet: assert property (@(posedge clk_i) in_reset_win |->
		(period_o == '0 && !err_o && !rdy_o && !stb_o && !ack_o && !debug_stb_o))
		else count_failure("an output is not 0 in or right after reset");
	a_period: assert property (@(posedge clk_i) disable iff (!arst_i)
		rdy_o |-> period_o == exp_period)
		else count_mismatch("period_o", exp_period, $sampled(period_o));
	a_no_err: assert property (@(posedge clk_i) disable iff (!arst_i) rdy_o |-> !err_o)
		else count_failure("err_o and rdy_o are high together");
	a_gap: assert property (@(posedge clk_i) disable iff (!arst_i)
		stb_rise && seen_rise |-> gap_cnt == exp_period)
		else count_mismatch("strobe period", exp_period, $sampled(gap_cnt));
	a_low: assert property (@(posedge clk_i) disable iff (!arst_i)
		stb_rise && seen_rise |-> low_cnt == T_CNT_WIDTH'(ZERO_HOLD))
		else count_mismatch("strobe low time", T_CNT_WIDTH'(ZERO_HOLD), $sampled(low_cnt));
	a_ack_rise: assert property (@(posedge clk_i) disable iff (!arst_i)
		$rose(ack_o) |-> req_i && rdy_o)
		else count_failure("ack_o rose without req_i and rdy_o");
	a_ack_fall: assert property (@(posedge clk_i) disable iff (!arst_i)
		$fell(ack_o) |-> !req_i)
		else count_failure("ack_o fell while req_i was still high");
	a_stb_gated: assert property (@(posedge clk_i) disable iff (!arst_i) !ack_o |-> !stb_o)
		else count_failure("stb_o high while ack_o is low");
	a_stb_pass: assert property (@(posedge clk_i) disable iff (!arst_i)
		ack_o |-> stb_o == debug_stb_o)
		else count_failure("stb_o differs from debug_stb_o while ack_o is high");
	a_ack_edge: assert property (@(posedge clk_i) disable iff (!arst_i)
		$changed(ack_o) |-> stb_rise)
		else count_failure("ack_o changed outside a strobe rising edge");

	//--------------------------------------------------------------------
	// helpers
	//--------------------------------------------------------------------
	task automatic count_mismatch(input string what, input logic [T_CNT_WIDTH-1:0] exp_v,
			input logic [T_CNT_WIDTH-1:0] act_v);
		fail_count++;
		$display("** Error [%s] %s: expected %0d, actual %0d", cur_test, what, exp_v, act_v);
	endtask

	task automatic count_failure(input string what);
		fail_count++;
		$display("** Error [%s] %s", cur_test, what);
	endtask

	function automatic int unsigned draw_period();
		int unsigned r;
		r = $unsigned($random(seed));
		return 40 + (r % 161);
	endfunction

	function automatic logic probe(input int sel);
		case (sel)
			SEL_RDY: return rdy_o;
			SEL_ERR: return err_o;
			default: return ack_o;
		endcase
	endfunction

	task automatic wait_for_level(input int sel, input logic level, input int unsigned limit,
			input string what);
		int unsigned n;
		n = 0;
		while (probe(sel) !== level && n < limit) begin
			@(posedge clk_i);
			n++;
		end
		assert (probe(sel) === level) else count_failure({"timeout waiting for ", what});
	endtask

	task automatic watchdog(input int unsigned cycles);
		repeat (cycles) @(posedge clk_i);
		$display("watchdog: run not finished after %0d cycles", cycles);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic start_test(input string name);
		cur_test     = name;
		fails_before = fail_count;
	endtask

	task automatic finish_test();
		tests_run++;
		$display("test %-14s done, %0d failed checks", cur_test, fail_count - fails_before);
	endtask

	// 3 cycles in reset, then 3 quiet cycles with sig_i idle
	task automatic apply_reset();
		arst_i       <= 1'b0;
		in_reset_win <= 1'b1;
		req_i        <= 1'b0;
		sig_period   <= 0;
		repeat (3) @(posedge clk_i);
		arst_i <= 1'b1;
		repeat (3) @(posedge clk_i);
		in_reset_win <= 1'b0;
	endtask

	task automatic do_handshake(input int unsigned p);
		req_i <= 1'b1;
		wait_for_level(SEL_ACK, 1'b1, 2 * p + 10, "ack_o to rise");
		repeat (p) @(posedge clk_i);     // gate stays open over a full period
		req_i <= 1'b0;
		wait_for_level(SEL_ACK, 1'b0, 2 * p + 10, "ack_o to fall");
		repeat (p) @(posedge clk_i);
	endtask

	task automatic run_period_test(input int idx, input int unsigned p);
		start_test($sformatf("period_%0d", idx));
		exp_period <= T_CNT_WIDTH'(p);
		apply_reset();
		sig_period <= p;
		wait_for_level(SEL_RDY, 1'b1, 5 * p + 50, "rdy_o");
		repeat (2 * p) @(posedge clk_i); // strobe shape checks
		do_handshake(p);
		finish_test();
	endtask

	task automatic run_error_test(input int unsigned p);
		start_test("short_period");
		exp_period <= T_CNT_WIDTH'(p);
		apply_reset();
		sig_period <= SHORT_PERIOD;
		wait_for_level(SEL_ERR, 1'b1, 200, "err_o");
		assert (!rdy_o) else count_failure("rdy_o high after a short period");
		sig_period <= p;                 // recover with a valid period
		wait_for_level(SEL_RDY, 1'b1, 5 * p + 50, "rdy_o after recovery");
		assert (!err_o) else count_failure("err_o still set after a valid period");
		repeat (2 * p) @(posedge clk_i);
		finish_test();
	endtask

	//--------------------------------------------------------------------
	// test sequence
	//--------------------------------------------------------------------
	initial begin
		int unsigned wd_cycles;
		wd_cycles = 2000;
		for (int i = 0; i < N_PERIODS; i++) begin
			periods[i] = draw_period();
			wd_cycles += 12 * periods[i];
		end
		fork
			watchdog(wd_cycles);
		join_none

		start_test("reset");
		apply_reset();
		repeat (4) @(posedge clk_i);
		finish_test();

		for (int i = 0; i < N_PERIODS - 1; i++)
			run_period_test(i, periods[i]);
		run_error_test(periods[N_PERIODS-1]);

		$display("%0d tests run, %0d failed checks", tests_run, fail_count);
		if (fail_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: flist.f
verilog/stb_pkg.sv
verilog/sync_ff.sv
verilog/split_counter.sv
verilog/two_cycle_adder.sv
verilog/period_meter.sv
verilog/stb_gen.sv
verilog/stb_req_port.sv
verilog/stb_sys_top.sv
verification/stb_sys_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the strobe subsystem testbench with Verilator
# the result is read from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module stb_sys_tb -f flist.f -o stb_sys_sim \
	&& ./obj_dir/stb_sys_sim | tee sim.log \
	|| { echo "verilator build or run failed"; exit 1; }

grep -q "SIMULATION PASSED" sim.log \
	&& { echo "run passed"; exit 0; } \
	|| { echo "run failed, see sim.log"; exit 1; }
